/* flist.f */
+incdir+include
logic/zx_bus_pkg.sv
logic/zx_regs_pkg.sv
logic/port_decoder.sv
logic/io_cycle_fsm.sv
logic/spi_bit_timer.sv
logic/spi_shifter.sv
logic/port_regs.sv
logic/zx_io_top.sv
test/zx_io_asserts.sv
test/zx_io_tb.sv

/* test/zx_io_tb.sv */
`timescale 1ns/1ps

`include "zx_io_defs.svh"

module zx_io_tb;

	localparam int BUS_TIMEOUT = 200; // clk cycles per bus cycle at most

	logic        clk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n;
	logic        mreq_n;
	logic        m1_n;
	logic        rd_n;
	logic        wr_n;
	logic [4:0]  keys_in;
	logic [4:0]  kj_in;
	logic        sd_miso;
	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic        wait_n;
	logic [2:0]  border;
	logic        beep;
	logic [7:0]  psd0;
	logic [7:0]  psd1;
	logic [7:0]  psd2;
	logic [7:0]  psd3;
	logic [7:0]  p7ffd;
	logic [7:0]  peff7;
	logic        dos;
	logic        sdcs_n;
	logic        sd_sck;
	logic        sd_mosi;

	logic [31:0] rng_state;
	logic [7:0]  slave_tx; // card side shift registers
	logic [7:0]  slave_rx;
	int          slave_bits;

	zx_io_top UUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.a       (a),
		.din     (din),
		.dout    (dout),
		.dataout (dataout),
		.porthit (porthit),
		.iorq_n  (iorq_n),
		.mreq_n  (mreq_n),
		.m1_n    (m1_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.wait_n  (wait_n),
		.keys_in (keys_in),
		.kj_in   (kj_in),
		.border  (border),
		.beep    (beep),
		.psd0    (psd0),
		.psd1    (psd1),
		.psd2    (psd2),
		.psd3    (psd3),
		.p7ffd   (p7ffd),
		.peff7   (peff7),
		.dos     (dos),
		.sdcs_n  (sdcs_n),
		.sd_sck  (sd_sck),
		.sd_mosi (sd_mosi),
		.sd_miso (sd_miso)
	);

	bind io_cycle_fsm zx_io_asserts u_asserts (
		.clk       (clk),
		.rst_n     (rst_n),
		.port_wr   (port_wr),
		.port_rd   (port_rd),
		.spi_valid (spi_valid),
		.spi_ready (spi_ready),
		.wait_n    (wait_n),
		.state     (state)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// mode 0 card model, MISO changes after falling SCK
	always @(posedge sd_sck)
	begin
		slave_rx = {slave_rx[6:0], sd_mosi};
		slave_bits++;
	end

	always @(negedge sd_sck)
	begin
		#2;
		slave_tx = {slave_tx[6:0], 1'b1};
		sd_miso  = slave_tx[7];
	end

	// a failed FSM assertion ends the run at the next clock
	always @(posedge clk)
	begin
		if (UUT.u_fsm.u_asserts.fail_count != 0)
			stop_on_error("An assertion on the bus cycle FSM failed, see the error above");
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			stop_on_error($sformatf("Mismatch at %0t ns: %s actual %0h expected %0h",
				$time, name, actual, expected));
	endtask

	task automatic check_dacs(input logic [7:0] e0, input logic [7:0] e1,
		input logic [7:0] e2, input logic [7:0] e3);
		check_value("psd0", psd0, e0);
		check_value("psd1", psd1, e1);
		check_value("psd2", psd2, e2);
		check_value("psd3", psd3, e3);
	endtask

	task automatic load_slave(input logic [7:0] b);
		slave_tx   = b;
		sd_miso    = b[7]; // first bit ready before the first rise
		slave_bits = 0;
	endtask

	// runs the clocks of one bus phase until wait_n lets the cycle end
	task automatic wait_cycle_end(output int low_cycles);
		int n;
		bit done;
		low_cycles = 0;
		done = 1'b0;
		for (n = 1; n <= BUS_TIMEOUT && !done; n++)
		begin
			@(posedge clk);
			#2;
			if (!wait_n)
				low_cycles++;
			else if (n >= 3)
				done = 1'b1; // strobe edge and register edge have passed
		end
		if (!done)
			stop_on_error("Timeout: wait_n never returned high, the bus cycle hung");
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data,
		output int low_cycles);
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		wait_cycle_end(low_cycles);
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		@(posedge clk); // fsm leaves HOLD here
		#2;
	endtask

	task automatic io_read(input logic [15:0] addr, output logic [7:0] data,
		output logic hit, output logic drv, output int low_cycles);
		a      = addr;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		wait_cycle_end(low_cycles);
		data   = dout; // z80 samples at the end of T3
		hit    = porthit;
		drv    = dataout;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		@(posedge clk);
		#2;
	endtask

	task automatic m1_fetch(input logic [15:0] addr);
		a      = addr;
		mreq_n = 1'b0;
		m1_n   = 1'b0;
		@(posedge clk);
		#2;
		mreq_n = 1'b1;
		m1_n   = 1'b1;
		@(posedge clk);
		#2;
	endtask

	task automatic after_reset();
		check_value("p7ffd", p7ffd, 8'h00);
		check_value("peff7", peff7, 8'h00);
		check_value("sdcs_n", sdcs_n, 1'b1);
		check_value("wait_n", wait_n, 1'b1);
		check_value("dos", dos, 1'b0);
		check_value("border", border, 3'd0);
	endtask

	task automatic paging();
		int low;
		io_write(16'h7FFD, 8'h03, low);
		check_value("p7ffd", p7ffd, 8'h03);
		io_write(16'h7FFD, 8'h25, low); // lock48 with page 5
		io_write(16'h7FFD, 8'h07, low);
		check_value("p7ffd locked", p7ffd, 8'h25);
		io_write(16'hEFF7, 8'h14, low); // block1m and turbo_off
		check_value("peff7", peff7, 8'h10);
		check_value("p7ffd 1m block", p7ffd, 8'h05);
		io_write(16'h7FFD, 8'hF3, low); // rom bit set for the DOS part
		check_value("p7ffd past lock", p7ffd, 8'h13);
	endtask

	task automatic fe_port();
		int low;
		logic [7:0] dat;
		logic hit;
		logic drv;
		io_write({8'h00, `ZX_PORT_FE}, 8'h15, low);
		check_value("border", border, 3'd5);
		check_value("beep", beep, 1'b1);
		check_dacs(8'hFF, 8'hFF, 8'hFF, 8'hFF);
		io_write({8'h00, `ZX_PORT_FE}, 8'h02, low);
		check_value("border", border, 3'd2);
		check_value("beep", beep, 1'b0);
		check_dacs(8'h00, 8'h00, 8'h00, 8'h00);
		keys_in = 5'h0A;
		io_read({8'hFE, `ZX_PORT_FE}, dat, hit, drv, low);
		check_value("dout fe", dat, 8'h8A);
		check_value("porthit fe", hit, 1'b1);
		check_value("dataout fe", drv, 1'b1);
		check_value("wait cycles fe", low, 0);
		io_read(16'h00AB, dat, hit, drv, low); // nobody owns AB
		check_value("dout unowned", dat, 8'hFF);
		check_value("porthit unowned", hit, 1'b0);
		check_value("dataout unowned", drv, 1'b0);
	endtask

	task automatic dac_channels();
		int low;
		io_write({8'h00, `ZX_PORT_SD2}, 8'h5A, low);
		check_dacs(8'h00, 8'h00, 8'h5A, 8'h00);
		io_write({8'h00, `ZX_PORT_CVX1}, 8'hC3, low);
		check_dacs(8'hC3, 8'hC3, 8'hC3, 8'hC3);
	endtask

	task automatic sd_transfer();
		int low;
		logic [7:0] card_byte;
		logic [7:0] dat;
		logic hit;
		logic drv;
		io_write({8'h00, `ZX_PORT_SDCFG}, 8'hFD, low); // bit 1 clear selects the card
		check_value("sdcs_n", sdcs_n, 1'b0);
		rng_state = xorshift32(rng_state);
		load_slave(rng_state[7:0]);
		io_write({8'h00, `ZX_PORT_SDDAT}, 8'hA5, low);
		// strobe edge, accept edge, 16 half periods, then release edge
		check_value("wait_n low cycles", low, 16 * `ZX_SPI_HALF + 2);
		check_value("card mosi byte", slave_rx, 8'hA5);
		check_value("sck rising edges", slave_bits, 8);
		check_value("sd_sck idle", sd_sck, 1'b0);
		rng_state = xorshift32(rng_state);
		card_byte = rng_state[7:0];
		load_slave(card_byte);
		io_read({8'h00, `ZX_PORT_SDDAT}, dat, hit, drv, low);
		check_value("sddat read", dat, card_byte);
		check_value("dataout sddat", drv, 1'b1);
		check_value("card mosi on read", slave_rx, 8'hFF);
		check_value("wait_n low cycles read", low, 16 * `ZX_SPI_HALF + 2);
	endtask

	task automatic dos_flag();
		int low;
		logic [7:0] dat;
		logic hit;
		logic drv;
		kj_in = 5'h13;
		m1_fetch(16'h3D00);
		check_value("dos after 3D00", dos, 1'b1);
		io_read({8'h00, `ZX_PORT_KJOY}, dat, hit, drv, low);
		check_value("porthit 1F in dos", hit, 1'b0);
		check_value("dout 1F in dos", dat, 8'hFF);
		m1_fetch(16'h8000);
		check_value("dos after 8000", dos, 1'b0);
		io_read({8'h00, `ZX_PORT_KJOY}, dat, hit, drv, low);
		check_value("porthit 1F", hit, 1'b1);
		check_value("dout kjoy", dat, 8'h13);
	endtask

	initial
	begin
		rst_n       = 1'b0;
		a           = 16'h0000;
		din         = 8'h00;
		iorq_n      = 1'b1;
		mreq_n      = 1'b1;
		m1_n        = 1'b1;
		rd_n        = 1'b1;
		wr_n        = 1'b1;
		keys_in     = 5'h1F; // no key pressed
		kj_in       = 5'h00;
		sd_miso     = 1'b1;
		slave_tx    = 8'hFF;
		slave_rx    = 8'h00;
		slave_bits  = 0;
		rng_state   = 32'd69;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;
		after_reset();
		paging();
		fe_port();
		dac_channels();
		sd_transfer();
		dos_flag();
		if (UUT.u_fsm.u_asserts.fail_count == 0)
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
		else
			stop_on_error("An assertion on the bus cycle FSM failed during the run");
	end

endmodule

/* test/zx_io_asserts.sv */
`timescale 1ns/1ps

module zx_io_asserts (
	input logic                     clk,
	input logic                     rst_n,
	input logic                     port_wr,
	input logic                     port_rd,
	input logic                     spi_valid,
	input logic                     spi_ready,
	input logic                     wait_n,
	input zx_bus_pkg::cycle_state_e state
);

	int fail_count = 0; // failed assertions so far

	// a bus cycle is either a read or a write
	a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(port_wr && port_rd))
		else
		begin
			fail_count++;
			$error("port_wr and port_rd high on the same cycle");
		end

	a_wr_single: assert property (@(posedge clk) disable iff (!rst_n) port_wr |=> !port_wr)
		else
		begin
			fail_count++;
			$error("port_wr longer than one cycle");
		end

	a_rd_single: assert property (@(posedge clk) disable iff (!rst_n) port_rd |=> !port_rd)
		else
		begin
			fail_count++;
			$error("port_rd longer than one cycle");
		end

	// request may not be withdrawn before the shifter takes it
	a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(spi_valid && !spi_ready) |=> spi_valid)
		else
		begin
			fail_count++;
			$error("spi_valid dropped before it was accepted");
		end

	a_wait_in_spi: assert property (@(posedge clk) disable iff (!rst_n)
		(state == zx_bus_pkg::SPI_WAIT) |-> !wait_n)
		else
		begin
			fail_count++;
			$error("wait_n high while a transfer is running");
		end

endmodule

/* logic/zx_io_top.sv */
`timescale 1ns/1ps

module zx_io_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit,
	input  logic        iorq_n,
	input  logic        mreq_n,
	input  logic        m1_n,
	input  logic        rd_n,
	input  logic        wr_n,
	output logic        wait_n,
	input  logic [4:0]  keys_in,
	input  logic [4:0]  kj_in,
	output logic [2:0]  border,
	output logic        beep,
	output logic [7:0]  psd0,
	output logic [7:0]  psd1,
	output logic [7:0]  psd2,
	output logic [7:0]  psd3,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic        dos,
	output logic        sdcs_n,
	output logic        sd_sck,
	output logic        sd_mosi,
	input  logic        sd_miso
);

	zx_bus_pkg::port_sel_e port_sel;
	logic       port_wr;
	logic       spi_valid;
	logic       spi_ready;
	logic       spi_done;
	logic [7:0] spi_rdata;
	wire  [7:0] spi_wdata = wr_n ? 8'hFF : din; // a read clocks out all ones

	port_decoder u_dec (
		.a        (a),
		.dos      (dos),
		.iorq_n   (iorq_n),
		.rd_n     (rd_n),
		.port_sel (port_sel),
		.porthit  (porthit),
		.dataout  (dataout)
	);

	io_cycle_fsm u_fsm (
		.clk       (clk),
		.rst_n     (rst_n),
		.iorq_n    (iorq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.port_sel  (port_sel),
		.port_wr   (port_wr),
		.port_rd   (),
		.spi_valid (spi_valid),
		.spi_ready (spi_ready),
		.spi_done  (spi_done),
		.wait_n    (wait_n)
	);

	spi_shifter u_spi (
		.clk       (clk),
		.rst_n     (rst_n),
		.spi_valid (spi_valid),
		.spi_ready (spi_ready),
		.wdata     (spi_wdata),
		.rdata     (spi_rdata),
		.spi_done  (spi_done),
		.sd_sck    (sd_sck),
		.sd_mosi   (sd_mosi),
		.sd_miso   (sd_miso)
	);

	port_regs u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.port_sel  (port_sel),
		.port_wr   (port_wr),
		.din       (din),
		.a         (a),
		.mreq_n    (mreq_n),
		.m1_n      (m1_n),
		.keys_in   (keys_in),
		.kj_in     (kj_in),
		.spi_done  (spi_done),
		.spi_rdata (spi_rdata),
		.dout      (dout),
		.border    (border),
		.beep      (beep),
		.psd0      (psd0),
		.psd1      (psd1),
		.psd2      (psd2),
		.psd3      (psd3),
		.p7ffd     (p7ffd),
		.peff7     (peff7),
		.dos       (dos),
		.sdcs_n    (sdcs_n)
	);

endmodule

/* logic/port_regs.sv */
`timescale 1ns/1ps

`include "zx_io_defs.svh"

module port_regs (
	input  logic                  clk,
	input  logic                  rst_n,
	input  zx_bus_pkg::port_sel_e port_sel,
	input  logic                  port_wr,
	input  logic [7:0]            din,
	input  logic [15:0]           a,
	input  logic                  mreq_n,
	input  logic                  m1_n,
	input  logic [4:0]            keys_in,
	input  logic [4:0]            kj_in,
	input  logic                  spi_done,
	input  logic [7:0]            spi_rdata,
	output logic [7:0]            dout,
	output logic [2:0]            border,
	output logic                  beep,
	output logic [7:0]            psd0,
	output logic [7:0]            psd1,
	output logic [7:0]            psd2,
	output logic [7:0]            psd3,
	output logic [7:0]            p7ffd,
	output logic [7:0]            peff7,
	output logic                  dos,
	output logic                  sdcs_n
);

	zx_regs_pkg::p7ffd_u p7ffd_r;
	zx_regs_pkg::eff7_t  peff7_r;
	zx_regs_pkg::fe_t    fe_wr;
	logic [7:0]          sd_rx; // last byte from the card
	logic                block7ffd;

	assign fe_wr     = zx_regs_pkg::fe_t'(din);
	assign block7ffd = p7ffd_r.f.lock48 && !peff7_r.block1m;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_r.raw <= `ZX_RST_P7FFD;
			peff7_r     <= `ZX_RST_PEFF7;
			sdcs_n      <= `ZX_RST_SDCS_N;
		end
		else if (port_wr)
		begin
			if (port_sel == zx_bus_pkg::P7FFD && !block7ffd)
				p7ffd_r.raw <= din;
			if (port_sel == zx_bus_pkg::EFF7)
				peff7_r <= din;
			if (port_sel == zx_bus_pkg::SDCFG)
				sdcs_n <= din[1];
		end
	end

	// with block1m the upper page bits are gone
	assign p7ffd = peff7_r.block1m ? {3'b000, p7ffd_r.raw[4:0]} : p7ffd_r.raw;
	assign peff7 = peff7_r.block1m ?
		{peff7_r.rsv7, 1'b0, peff7_r.rsv5, peff7_r.turbo_off, 3'b000, peff7_r.p16c} :
		peff7_r;

	// border, beeper and the four DAC channels
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border <= 3'd0;
			beep   <= 1'b0;
			psd0   <= 8'h00;
			psd1   <= 8'h00;
			psd2   <= 8'h00;
			psd3   <= 8'h00;
		end
		else if (port_wr)
		begin
			case (port_sel)
				zx_bus_pkg::FE:
				begin
					border <= fe_wr.border;
					beep   <= fe_wr.beep;
					psd0   <= {8{fe_wr.beep}}; // beeper through the DACs
					psd1   <= {8{fe_wr.beep}};
					psd2   <= {8{fe_wr.beep}};
					psd3   <= {8{fe_wr.beep}};
				end
				zx_bus_pkg::COVOX:
				begin
					psd0 <= din;
					psd1 <= din;
					psd2 <= din;
					psd3 <= din;
				end
				zx_bus_pkg::SD_DAC0: psd0 <= din;
				zx_bus_pkg::SD_DAC1: psd1 <= din;
				zx_bus_pkg::SD_DAC2: psd2 <= din;
				zx_bus_pkg::SD_DAC3: psd3 <= din;
				default: ;
			endcase
		end
	end

	// DOS rom follows the opcode fetch address
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			dos <= 1'b0;
		else if (!mreq_n && !m1_n)
		begin
			if (a[15:8] == 8'h3D && p7ffd_r.f.rom)
				dos <= 1'b1; // entry point in basic48 rom
			else if (a[15:14] != 2'b00)
				dos <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (spi_done)
			sd_rx <= spi_rdata;
	end

	always_comb
	begin
		case (port_sel)
			zx_bus_pkg::FE:    dout = {1'b1, 1'b0, 1'b0, keys_in}; // no tape input
			zx_bus_pkg::KJOY:  dout = {3'b000, kj_in};
			zx_bus_pkg::SDCFG: dout = 8'h00; // card present, not write protected
			zx_bus_pkg::SDDAT: dout = sd_rx;
			default:           dout = 8'hFF;
		endcase
	end

endmodule

/* logic/spi_shifter.sv */
`timescale 1ns/1ps

module spi_shifter (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       spi_valid,
	output logic       spi_ready,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	output logic       spi_done,
	output logic       sd_sck,
	output logic       sd_mosi,
	input  logic       sd_miso
);

	logic       busy;
	logic       sck_edge;
	logic       last;
	logic [7:0] tx_sr;
	logic [7:0] rx_sr;

	spi_bit_timer u_timer (
		.clk      (clk),
		.rst_n    (rst_n),
		.run      (busy),
		.sck_edge (sck_edge),
		.last     (last)
	);

	assign spi_ready = !busy;
	assign sd_mosi   = tx_sr[7]; // msb first, set up before the first rise
	assign rdata     = rx_sr;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy     <= 1'b0;
			sd_sck   <= 1'b0;
			spi_done <= 1'b0;
		end
		else
		begin
			spi_done <= 1'b0;
			if (spi_valid && spi_ready)
				busy <= 1'b1;
			else if (sck_edge)
			begin
				sd_sck <= !sd_sck;
				if (last)
				begin
					busy     <= 1'b0;
					spi_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (spi_valid && spi_ready)
			tx_sr <= wdata;
		else if (sck_edge)
		begin
			if (sd_sck)
				tx_sr <= {tx_sr[6:0], 1'b1}; // falling edge, next bit out
			else
				rx_sr <= {rx_sr[6:0], sd_miso}; // rising edge sample
		end
	end

endmodule

/* logic/spi_bit_timer.sv */
`timescale 1ns/1ps

`include "zx_io_defs.svh"

module spi_bit_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	output logic sck_edge,
	output logic last
);

	logic [7:0] div_cnt;
	logic [3:0] half_cnt; // SCK half-periods done so far

	assign sck_edge = run && (div_cnt == 8'(`ZX_SPI_HALF - 1));
	assign last     = (half_cnt == 4'd15); // 16th half-period, SCK back low

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			div_cnt  <= 8'd0;
			half_cnt <= 4'd0;
		end
		else if (!run)
		begin
			div_cnt  <= 8'd0;
			half_cnt <= 4'd0;
		end
		else if (sck_edge)
		begin
			div_cnt  <= 8'd0;
			half_cnt <= half_cnt + 4'd1;
		end
		else
			div_cnt <= div_cnt + 8'd1;
	end

endmodule

/* logic/io_cycle_fsm.sv */
`timescale 1ns/1ps

module io_cycle_fsm (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  zx_bus_pkg::port_sel_e port_sel,
	output logic                  port_wr,
	output logic                  port_rd,
	output logic                  spi_valid,
	input  logic                  spi_ready,
	input  logic                  spi_done,
	output logic                  wait_n
);

	zx_bus_pkg::cycle_state_e state;
	logic rd_cycle; // direction seen when the cycle started

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= zx_bus_pkg::IDLE;
			rd_cycle  <= 1'b0;
			port_wr   <= 1'b0;
			port_rd   <= 1'b0;
			spi_valid <= 1'b0;
			wait_n    <= 1'b1;
		end
		else
		begin
			port_wr <= 1'b0;
			port_rd <= 1'b0;
			if (spi_valid && spi_ready)
				spi_valid <= 1'b0; // shifter took it
			case (state)
				zx_bus_pkg::IDLE:
					if (!iorq_n && !(rd_n && wr_n))
					begin
						rd_cycle <= !rd_n;
						state    <= zx_bus_pkg::STROBE;
					end
				zx_bus_pkg::STROBE:
				begin
					port_rd <= rd_cycle;
					port_wr <= !rd_cycle;
					if (port_sel == zx_bus_pkg::SDDAT)
					begin
						// either direction runs one byte on the card
						spi_valid <= 1'b1;
						wait_n    <= 1'b0;
						state     <= zx_bus_pkg::SPI_WAIT;
					end
					else
						state <= zx_bus_pkg::HOLD;
				end
				zx_bus_pkg::SPI_WAIT:
					if (spi_done)
					begin
						wait_n <= 1'b1;
						state  <= zx_bus_pkg::HOLD;
					end
				default: // HOLD
					if (iorq_n)
						state <= zx_bus_pkg::IDLE;
			endcase
		end
	end

endmodule

/* logic/port_decoder.sv */
`timescale 1ns/1ps

`include "zx_io_defs.svh"

module port_decoder (
	input  logic [15:0]           a,
	input  logic                  dos,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	output zx_bus_pkg::port_sel_e port_sel,
	output logic                  porthit,
	output logic                  dataout
);

	logic [7:0] loa;

	assign loa = a[7:0];

	always_comb
	begin
		port_sel = zx_bus_pkg::NONE;
		if (loa == `ZX_PORT_FE)
			port_sel = zx_bus_pkg::FE;
		else if (loa == `ZX_PORT_FD && !a[15])
			port_sel = zx_bus_pkg::P7FFD;
		else if (loa == `ZX_PORT_F7 && !a[12])
			port_sel = zx_bus_pkg::EFF7;
		else if (loa == `ZX_PORT_CVX1 || loa == `ZX_PORT_CVX2)
			port_sel = zx_bus_pkg::COVOX;
		else if (loa == `ZX_PORT_SDCFG)
			port_sel = zx_bus_pkg::SDCFG;
		else if (loa == `ZX_PORT_SDDAT)
			port_sel = zx_bus_pkg::SDDAT;
		else if (!dos)
		begin
			// in DOS these addresses belong to the floppy controller
			if (loa == `ZX_PORT_KJOY && !rd_n)
				port_sel = zx_bus_pkg::KJOY; // joystick answers reads on 1F
			else if (loa == `ZX_PORT_SD0)
				port_sel = zx_bus_pkg::SD_DAC0;
			else if (loa == `ZX_PORT_SD1)
				port_sel = zx_bus_pkg::SD_DAC1;
			else if (loa == `ZX_PORT_SD2)
				port_sel = zx_bus_pkg::SD_DAC2;
			else if (loa == `ZX_PORT_SD3)
				port_sel = zx_bus_pkg::SD_DAC3;
		end
	end

	assign porthit = (port_sel != zx_bus_pkg::NONE);

	// we put data on the bus only for our own ports
	assign dataout = porthit && !iorq_n && !rd_n;

endmodule

/* logic/zx_regs_pkg.sv */
package zx_regs_pkg;

	// 7FFD split into fields, msb first
	typedef struct packed {
		logic [1:0] unused;
		logic       lock48; // freezes paging until next reset
		logic       rom;    // 48k basic rom selected
		logic       screen; // shadow screen
		logic [2:0] page;   // ram page at C000
	} p7ffd_t;

	// raw byte for the output port, fields for paging
	typedef union packed {
		logic [7:0] raw;
		p7ffd_t     f;
	} p7ffd_u;

	typedef struct packed {
		logic rsv7;
		logic rsv6;
		logic rsv5;
		logic turbo_off;
		logic rsv3;
		logic block1m; // back to plain 128k paging, lifts lock48
		logic rsv1;
		logic p16c;
	} eff7_t;

	// FE write layout
	typedef struct packed {
		logic [2:0] unused;
		logic       beep;
		logic       mic;
		logic [2:0] border;
	} fe_t;

endpackage

/* logic/zx_bus_pkg.sv */
package zx_bus_pkg;

	// decoded port, one value per owned register or read source
	typedef enum logic [3:0]
	{
		NONE,
		FE,
		P7FFD,
		EFF7,
		KJOY,     // 1F on a read
		SD_DAC0,
		SD_DAC1,  // 1F on a write
		SD_DAC2,
		SD_DAC3,
		COVOX,
		SDCFG,
		SDDAT
	} port_sel_e;

	// bus cycle tracking
	typedef enum logic [1:0]
	{
		IDLE,     // waiting for iorq with rd or wr
		STROBE,   // strobe goes out on the next edge
		SPI_WAIT, // z80 held in wait during a transfer
		HOLD      // wait for iorq_n to return high
	} cycle_state_e;

endpackage

/* include/zx_io_defs.svh */
`ifndef ZX_IO_DEFS_SVH
`define ZX_IO_DEFS_SVH

// low address byte of each owned port
`define ZX_PORT_FE    8'hFE // border, beeper, keyboard
`define ZX_PORT_FD    8'hFD // 7FFD paging, needs a15 low
`define ZX_PORT_F7    8'hF7 // EFF7 config, needs a12 low
`define ZX_PORT_KJOY  8'h1F // kempston joystick, read side

// soundrive channels, only outside DOS
`define ZX_PORT_SD0   8'h0F
`define ZX_PORT_SD1   8'h1F // shares the address with the joystick
`define ZX_PORT_SD2   8'h4F
`define ZX_PORT_SD3   8'h5F

// covox, both addresses load every channel
`define ZX_PORT_CVX1  8'hFB
`define ZX_PORT_CVX2  8'hDD

// z-controller style SD card ports
`define ZX_PORT_SDCFG 8'h77
`define ZX_PORT_SDDAT 8'h57

// clk cycles per SCK half-period
`define ZX_SPI_HALF   2

// register values after reset
`define ZX_RST_P7FFD  8'h00
`define ZX_RST_PEFF7  8'h00
`define ZX_RST_SDCS_N 1'b1 // card deselected

`endif
